//--- list.f
psram_spi_pkg.sv
psram_host_pkg.sv
psram_delay_timer.sv
psram_sequencer.sv
psram_wave_gen.sv
psram_read_capture.sv
psram_ctrl.sv
psram_ctrl_assertions.sv
tb_clock.sv
tb_psram_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the PSRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_psram_ctrl \
	--Mdir obj_dir -o sim_psram_ctrl
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_psram_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1

//--- tb_psram_ctrl.sv
// PSRAM controller testbench

module tb_psram_ctrl;
	import psram_spi_pkg::*;
	import psram_host_pkg::*;

	localparam int READY_LIMIT = 20000;
	localparam int BURST_LIMIT = 500;

	// Counter selectors for wait_for
	localparam int SEL_AWREADY = 0;
	localparam int SEL_ARREADY = 1;
	localparam int SEL_BVALID  = 2;
	localparam int SEL_RVALID  = 3;
	localparam int SEL_READY   = 4;

	logic       clk;
	logic       reset;
	spi_pads_t  pads;
	logic [7:0] spi_data_in = '0;
	logic       spi_rwds_in = 1'b0;
	logic       psram_ready;
	host_word_t wdata = '0;
	logic       wready;
	host_addr_t awaddr;
	logic       awvalid;
	logic       awready;
	logic       bvalid;
	logic [1:0] bresp;
	host_addr_t araddr;
	logic       arvalid;
	logic       arready;
	read_word_t rdata;
	logic       rvalid;

	int         seed = 78476;
	int         err_count = 0;
	int         test_errs = 0;
	int         test_count = 0;
	logic [7:0] resp_start = '0;
	logic [7:0] resp_byte = '0;
	logic [2:0] wr_pos = '0;
	host_word_t wr_words[$];

	// Monitor state, written only at the falling clock edge
	logic       prev_sclk = 1'b0;
	logic       ready_seen = 1'b0;
	logic       ready_dropped = 1'b0;
	int         aw_cnt = 0;
	int         ar_cnt = 0;
	int         wr_cnt = 0;
	int         b_cnt = 0;
	int         rv_cnt = 0;
	logic [7:0] out_bytes[$];
	logic [8:0] latched[$];
	read_word_t rd_words[$];

	logic [7:0] exp_bytes[$];
	event       abort_run;

	tb_clock u_clock (
		.clk (clk)
	);

	psram_ctrl u_psram_ctrl (
		.clk         (clk),
		.reset       (reset),
		.pads        (pads),
		.spi_data_in (spi_data_in),
		.spi_rwds_in (spi_rwds_in),
		.psram_ready (psram_ready),
		.wdata       (wdata),
		.wready      (wready),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.bvalid      (bvalid),
		.bresp       (bresp),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rvalid      (rvalid)
	);

	////////////////////////////////////////////////////////////
	// Pad responder and write data source
	////////////////////////////////////////////////////////////

	// Incrementing input byte while the bus is turned around
	always @(posedge clk) begin
		if (reset) begin
			resp_byte <= resp_start;
		end else if (pads.cs && !pads.data_oe) begin
			spi_data_in <= resp_byte;
			spi_rwds_in <= resp_byte[0];
			resp_byte   <= resp_byte + 8'd1;
		end
	end

	// Next word on each wready, eight per burst
	always @(posedge clk) begin
		if (wready) begin
			wr_pos <= wr_pos + 3'd1;
			wdata  <= wr_words[wr_pos + 3'd1];
		end else begin
			wdata <= wr_words[wr_pos];
		end
	end

	// Bus bytes, strobes and read words
	always @(negedge clk) begin
		if (!reset) begin
			// Both sclk edges carry a byte
			if (pads.sclk != prev_sclk && pads.data_oe) begin
				out_bytes.push_back(pads.data_out);
			end
			prev_sclk = pads.sclk;
			if (u_psram_ctrl.latch != 2'b00) begin
				latched.push_back({spi_rwds_in, spi_data_in});
			end
			if (awready) aw_cnt++;
			if (arready) ar_cnt++;
			if (wready) wr_cnt++;
			if (bvalid) b_cnt++;
			if (rvalid) begin
				rv_cnt++;
				rd_words.push_back(rdata);
			end
			if (psram_ready) begin
				ready_seen = 1'b1;
			end else if (ready_seen) begin
				ready_dropped = 1'b1;
			end
		end
	end

	// Timeout exit
	initial begin
		@(abort_run);
		$display("Test failures found");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic void push_twice(input logic [7:0] b);
		exp_bytes.push_back(b);
		exp_bytes.push_back(b);
	endfunction

	// Expected bus bytes of one command
	function automatic void push_expected(input psram_cmd_t cmd, input host_addr_t addr);
		logic [31:0] a;
		a = {7'd0, addr};
		case (cmd)
			cmd_reset: begin
				push_twice(8'h66);
				push_twice(8'h99);
			end
			cmd_read_id: begin
				// Command, then two zero address steps
				push_twice(8'h9F);
				for (int i = 0; i < 4; i++) exp_bytes.push_back(8'h00);
			end
			cmd_write_cr0: begin
				push_twice(8'h06);
				push_twice(8'h71);
				exp_bytes.push_back(CR0_ADDR[31:24]);
				exp_bytes.push_back(CR0_ADDR[23:16]);
				exp_bytes.push_back(CR0_ADDR[15:8]);
				exp_bytes.push_back(CR0_ADDR[7:0]);
				exp_bytes.push_back(8'h8F);
				exp_bytes.push_back(8'hEF);
				push_twice(8'h06);
			end
			default: begin
				if (cmd == cmd_read_mem) begin
					a[2:0] = 3'd0;
					push_twice(8'hEE);
				end else begin
					a[3:0] = 4'd0;
					push_twice(8'hDE);
				end
				exp_bytes.push_back(a[31:24]);
				exp_bytes.push_back(a[23:16]);
				exp_bytes.push_back(a[15:8]);
				exp_bytes.push_back(a[7:0]);
				// Write words high byte first
				if (cmd == cmd_write_mem) begin
					for (int i = 0; i < 8; i++) begin
						exp_bytes.push_back(wr_words[i][15:8]);
						exp_bytes.push_back(wr_words[i][7:0]);
					end
				end
			end
		endcase
	endfunction

	// Read word from two driven bytes in latch order
	function automatic read_word_t pair_word(input logic [8:0] first, input logic [8:0] second);
		read_word_t w;
		w.first  = first;
		w.second = second;
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	task automatic note_error();
		err_count++;
		test_errs++;
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %02h expected %02h", $time, what, got, exp);
			note_error();
		end
	endtask

	task automatic check_word(input string what, input read_word_t got, input read_word_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %05h expected %05h", $time, what, got, exp);
			note_error();
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %0b expected %0b", $time, what, got, exp);
			note_error();
		end
	endtask

	task automatic check_pads(input string what, input spi_pads_t got, input spi_pads_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %04h expected %04h", $time, what, got, exp);
			note_error();
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
			note_error();
		end
	endtask

	task automatic check_idle(input string what);
		check_pads({"pads ", what}, pads, '0);
		check_flag({"psram_ready ", what}, psram_ready, 1'b0);
		check_flag({"awready ", what}, awready, 1'b0);
		check_flag({"arready ", what}, arready, 1'b0);
		check_flag({"wready ", what}, wready, 1'b0);
		check_flag({"bvalid ", what}, bvalid, 1'b0);
		check_flag({"rvalid ", what}, rvalid, 1'b0);
	endtask

	// Bus bytes from base on against the reference
	task automatic compare_stream(input string what, input int base);
		int n;
		n = out_bytes.size() - base;
		if (n != exp_bytes.size()) begin
			$display("%s: %0d bytes seen on the bus, %0d expected", what, n, exp_bytes.size());
			note_error();
		end
		for (int i = 0; i < n && i < exp_bytes.size(); i++) begin
			check_byte($sformatf("%s byte %0d", what, i), out_bytes[base + i], exp_bytes[i]);
		end
	endtask

	function automatic int strobe_count(input int sel);
		case (sel)
			SEL_AWREADY: return aw_cnt;
			SEL_ARREADY: return ar_cnt;
			SEL_BVALID:  return b_cnt;
			SEL_RVALID:  return rv_cnt;
			default:     return int'(psram_ready);
		endcase
	endfunction

	// Returns on a rising edge once the count is reached
	task automatic wait_for(input string what, input int sel, input int target,
			input int limit);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (strobe_count(sel) < target && n < limit);
		if (strobe_count(sel) < target) begin
			$display("Timeout after %0d cycles waiting for %s", limit, what);
			-> abort_run;
			@(posedge clk);
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		check_flag("psram_ready held high", ready_dropped, 1'b0);
		$display("Test %0d %s: %s", test_count, name, (test_errs == 0) ? "ok" : "failed");
		test_errs = 0;
	endtask

	////////////////////////////////////////////////////////////
	// Host requests
	////////////////////////////////////////////////////////////

	task automatic run_requests(input string name, input bit do_wr, input bit do_rd);
		int         byte_base;
		int         lat_base;
		int         word_base;
		int         aw_base;
		int         ar_base;
		int         wr_base;
		int         b_base;
		int         rv_base;
		host_addr_t wa;
		host_addr_t ra;
		wa = host_addr_t'($random(seed));
		ra = host_addr_t'($random(seed));
		for (int i = 0; i < 8; i++) begin
			wr_words[i] = host_word_t'($random(seed));
		end
		byte_base = out_bytes.size();
		lat_base  = latched.size();
		word_base = rd_words.size();
		aw_base   = aw_cnt;
		ar_base   = ar_cnt;
		wr_base   = wr_cnt;
		b_base    = b_cnt;
		rv_base   = rv_cnt;
		// Write is served first when both are raised
		exp_bytes.delete();
		if (do_wr) push_expected(cmd_write_mem, wa);
		if (do_rd) push_expected(cmd_read_mem, ra);

		@(posedge clk);
		awaddr  <= wa;
		araddr  <= ra;
		awvalid <= do_wr;
		arvalid <= do_rd;
		if (do_wr) begin
			wait_for("awready", SEL_AWREADY, aw_base + 1, BURST_LIMIT);
			awvalid <= 1'b0;
		end
		if (do_rd) begin
			wait_for("arready", SEL_ARREADY, ar_base + 1, BURST_LIMIT);
			arvalid <= 1'b0;
		end
		if (do_wr) wait_for("bvalid", SEL_BVALID, b_base + 1, BURST_LIMIT);
		if (do_rd) wait_for("rvalid", SEL_RVALID, rv_base + 4, BURST_LIMIT);
		// Let any stray strobe show up
		repeat (20) @(posedge clk);

		check_count("awready pulses", aw_cnt - aw_base, int'(do_wr));
		check_count("arready pulses", ar_cnt - ar_base, int'(do_rd));
		check_count("wready pulses", wr_cnt - wr_base, 8 * int'(do_wr));
		check_count("bvalid pulses", b_cnt - b_base, int'(do_wr));
		check_count("rvalid pulses", rv_cnt - rv_base, 4 * int'(do_rd));
		check_count("bresp", int'(bresp), 0);
		compare_stream(name, byte_base);
		if (do_rd) begin
			if (latched.size() - lat_base != 8 || rd_words.size() - word_base != 4) begin
				$display("%s: %0d latched bytes and %0d read words, 8 and 4 expected",
					name, latched.size() - lat_base, rd_words.size() - word_base);
				note_error();
			end else begin
				for (int k = 0; k < 4; k++) begin
					check_word($sformatf("%s rdata %0d", name, k), rd_words[word_base + k],
						pair_word(latched[lat_base + 2 * k], latched[lat_base + 2 * k + 1]));
				end
			end
		end
		end_test(name);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset      = 1'b1;
		awvalid    = 1'b0;
		arvalid    = 1'b0;
		awaddr     = '0;
		araddr     = '0;
		resp_start = 8'($random(seed));
		for (int i = 0; i < 8; i++) begin
			wr_words.push_back('0);
		end

		// Reset held for 16 cycles, everything quiet
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			if (i == 15) reset <= 1'b0;
			@(negedge clk);
			check_idle("in reset");
		end
		repeat (20) begin
			@(negedge clk);
			check_idle("after reset");
		end
		end_test("reset_idle");

		// Start-up commands up to psram_ready
		exp_bytes.delete();
		push_expected(cmd_reset, '0);
		push_expected(cmd_read_id, '0);
		push_expected(cmd_write_cr0, '0);
		wait_for("psram_ready", SEL_READY, 1, READY_LIMIT);
		repeat (10) @(posedge clk);
		compare_stream("startup", 0);
		check_flag("psram_ready", psram_ready, 1'b1);
		check_count("awready before requests", aw_cnt, 0);
		end_test("startup_sequence");

		run_requests("write_burst", 1'b1, 1'b0);
		run_requests("read_burst", 1'b0, 1'b1);
		run_requests("write_then_read", 1'b1, 1'b1);

		$display("Tests run: %0d, checks failed: %0d", test_count, err_count);
		if (err_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- tb_clock.sv
// Testbench clock source

module tb_clock (
	output logic clk
);
	// Half of the 10 unit period
	localparam int HALF_PERIOD = 5;

	initial begin
		clk = 1'b0;
	end

	always begin
		#HALF_PERIOD clk = ~clk;
	end

endmodule

//--- psram_ctrl_assertions.sv
// Bound protocol checks for the PSRAM controller

module psram_ctrl_assertions (
	input logic                     clk,
	input logic                     reset,
	input psram_spi_pkg::spi_pads_t pads,
	input logic                     awready,
	input logic                     arready,
	input logic                     rvalid,
	input logic                     psram_ready
);

	// Output enables only inside a cs frame
	oe_inside_cs: assert property (@(posedge clk) disable iff (reset)
		!pads.cs |-> !(pads.data_oe || pads.rwds_oe))
		else $error("data_oe or rwds_oe high while cs is low");

	// Write and read address accepted in different cycles
	single_addr_accept: assert property (@(posedge clk) disable iff (reset)
		!(awready && arready))
		else $error("awready and arready high together");

	// No read data before start-up completes
	rvalid_after_ready: assert property (@(posedge clk) disable iff (reset)
		rvalid |-> psram_ready)
		else $error("rvalid high before psram_ready");

endmodule

bind psram_ctrl psram_ctrl_assertions u_assertions (
	.clk         (clk),
	.reset       (reset),
	.pads        (pads),
	.awready     (awready),
	.arready     (arready),
	.rvalid      (rvalid),
	.psram_ready (psram_ready)
);

//--- psram_ctrl.sv
// PSRAM SPI8 controller top level

module psram_ctrl (
	input  logic                       clk,
	input  logic                       reset,
	output psram_spi_pkg::spi_pads_t   pads,
	input  logic [7:0]                 spi_data_in,
	input  logic                       spi_rwds_in,
	output logic                       psram_ready,
	input  psram_host_pkg::host_word_t wdata,
	output logic                       wready,
	input  psram_host_pkg::host_addr_t awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	output logic                       bvalid,
	output logic [1:0]                 bresp,
	input  psram_host_pkg::host_addr_t araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output psram_host_pkg::read_word_t rdata,
	output logic                       rvalid
);
	import psram_spi_pkg::*;
	import psram_host_pkg::*;

	psram_cmd_t start_cmd;
	host_addr_t mem_addr;
	logic       start;
	logic       last_step;
	logic       phase_end;
	logic       timer_load;
	logic       timer_sel;
	logic       expired;
	logic [1:0] latch;

	assign bresp = RESP_OKAY;

	psram_delay_timer u_timer (
		.clk     (clk),
		.reset   (reset),
		.load    (timer_load),
		.sel     (timer_sel),
		.expired (expired)
	);

	psram_sequencer u_sequencer (
		.clk         (clk),
		.reset       (reset),
		.awvalid     (awvalid),
		.awaddr      (awaddr),
		.arvalid     (arvalid),
		.araddr      (araddr),
		.last_step   (last_step),
		.phase_end   (phase_end),
		.expired     (expired),
		.awready     (awready),
		.arready     (arready),
		.bvalid      (bvalid),
		.psram_ready (psram_ready),
		.start_cmd   (start_cmd),
		.start       (start),
		.timer_load  (timer_load),
		.timer_sel   (timer_sel),
		.mem_addr    (mem_addr)
	);

	psram_wave_gen u_wave_gen (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.start_cmd (start_cmd),
		.mem_addr  (mem_addr),
		.wdata     (wdata),
		.pads      (pads),
		.latch     (latch),
		.wready    (wready),
		.last_step (last_step),
		.phase_end (phase_end)
	);

	psram_read_capture u_capture (
		.clk     (clk),
		.reset   (reset),
		.rwds_in (spi_rwds_in),
		.data_in (spi_data_in),
		.latch   (latch),
		.rdata   (rdata),
		.rvalid  (rvalid)
	);

endmodule

//--- psram_read_capture.sv
// PSRAM read data capture

module psram_read_capture (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       rwds_in,
	input  logic [7:0]                 data_in,
	input  logic [1:0]                 latch,
	output psram_host_pkg::read_word_t rdata,
	output logic                       rvalid
);
	import psram_host_pkg::*;

	rd_byte_t   in_byte;
	rd_byte_t   first_byte;
	read_word_t word;
	logic [1:0] latch_q;
	logic       word_done;

	// Input byte and strobe, kept in step
	always_ff @(posedge clk) begin
		in_byte <= {rwds_in, data_in};
		if (latch_q[0]) begin
			first_byte <= in_byte;
		end
		if (latch_q[1]) begin
			word <= {first_byte, in_byte};
		end
		if (word_done) begin
			rdata <= word;
		end
	end

	// Two-stage valid delay
	always_ff @(posedge clk) begin
		if (reset) begin
			latch_q   <= '0;
			word_done <= 1'b0;
			rvalid    <= 1'b0;
		end else begin
			latch_q   <= latch;
			word_done <= latch_q[1];
			rvalid    <= word_done;
		end
	end

endmodule

//--- psram_wave_gen.sv
// PSRAM bus waveform generator

module psram_wave_gen (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       start,
	input  psram_spi_pkg::psram_cmd_t  start_cmd,
	input  psram_host_pkg::host_addr_t mem_addr,
	input  psram_host_pkg::host_word_t wdata,
	output psram_spi_pkg::spi_pads_t   pads,
	output logic [1:0]                 latch,
	output logic                       wready,
	output logic                       last_step,
	output logic                       phase_end
);
	import psram_spi_pkg::*;
	import psram_host_pkg::*;

	typedef struct packed {
		spi_pads_t  pads;
		logic [1:0] latch;
	} wave_entry_t;

	logic [$clog2(PHASES)-1:0]          phase;
	logic [$clog2(PHASES)-1:0]          phase_d;
	logic [NUM_CMDS-1:0][MAX_STEPS-1:0] chain;
	logic [NUM_CMDS-1:0][MAX_STEPS-1:0] chain_d;
	host_word_t                         word_reg;
	host_word_t                         word_sel;
	logic [31:0]                        addr_bytes;
	wave_entry_t                        next_entry;

	function automatic int step_count(input psram_cmd_t cmd);
		case (cmd)
			cmd_reset:     return RESET_STEPS;
			cmd_read_id:   return READ_ID_STEPS;
			cmd_write_cr0: return WRITE_CR0_STEPS;
			cmd_read_mem:  return READ_MEM_STEPS;
			default:       return WRITE_MEM_STEPS;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Command table, one entry per step and phase
	////////////////////////////////////////////////////////////

	function automatic wave_entry_t step_entry(input psram_cmd_t cmd, input int step,
			input logic [1:0] ph, input logic [31:0] addr, input host_word_t word);
		wave_entry_t e;
		logic        active;
		logic        drive;
		logic        rwds_drive;
		logic [7:0]  b0;
		logic [7:0]  b1;
		logic        mark0;
		logic        mark1;
		active     = 1'b1;
		drive      = step < CMD_HDR_STEPS;
		rwds_drive = 1'b0;
		mark0      = 1'b0;
		mark1      = 1'b0;
		// Address steps carry bytes 3,2 then 1,0
		b0 = (step == 1) ? addr[31:24] : addr[15:8];
		b1 = (step == 1) ? addr[23:16] : addr[7:0];
		case (cmd)
			cmd_reset: begin
				// Step 1 drops cs between the two commands
				active = (step != 1);
				drive  = active;
				b0     = (step == 0) ? RESET_ENABLE_BYTE : RESET_BYTE;
				b1     = b0;
			end
			cmd_read_id: begin
				// ID bytes are clocked out but not kept
				active = step < READ_ID_STEPS - 1;
				b0     = (step == 0) ? READ_ID_BYTE : 8'h00;
				b1     = b0;
			end
			cmd_write_cr0: begin
				active = (step != 1) && (step != 6);
				drive  = active;
				case (step)
					2: begin
						b0 = WRITE_REG_BYTE;
						b1 = WRITE_REG_BYTE;
					end
					3: begin
						b0 = CR0_ADDR[31:24];
						b1 = CR0_ADDR[23:16];
					end
					4: begin
						b0 = CR0_ADDR[15:8];
						b1 = CR0_ADDR[7:0];
					end
					5: begin
						b0 = CR0_VALUE[15:8];
						b1 = CR0_VALUE[7:0];
					end
					default: begin
						// Write enable, sent before and after
						b0 = WRITE_ENABLE_BYTE;
						b1 = WRITE_ENABLE_BYTE;
					end
				endcase
			end
			cmd_read_mem: begin
				active = step < READ_MEM_STEPS - 1;
				// First byte in phase 2, pair completes next phase 0
				mark0  = (step >= FIRST_DATA_STEP) && (step < READ_MEM_STEPS - 1);
				mark1  = step > FIRST_DATA_STEP;
				if (step == 0) begin
					b0 = READ_MEM_BYTE;
					b1 = READ_MEM_BYTE;
				end
			end
			default: begin
				// Write burst, data steps also drive rwds low
				drive      = (step < CMD_HDR_STEPS) || (step >= FIRST_DATA_STEP);
				rwds_drive = step >= FIRST_DATA_STEP;
				if (step == 0) begin
					b0 = WRITE_MEM_BYTE;
					b1 = WRITE_MEM_BYTE;
				end else if (step >= FIRST_DATA_STEP) begin
					b0 = word[15:8];
					b1 = word[7:0];
				end
			end
		endcase
		e.pads.cs       = active;
		e.pads.sclk     = active && (ph == 2'd1 || ph == 2'd2);
		e.pads.data_oe  = drive;
		e.pads.data_out = drive ? (ph[1] ? b1 : b0) : 8'h00;
		e.pads.rwds_oe  = rwds_drive;
		e.pads.rwds_out = 1'b0;
		e.latch[0]      = mark0 && (ph == 2'd2);
		e.latch[1]      = mark1 && (ph == 2'd0);
		return e;
	endfunction

	////////////////////////////////////////////////////////////
	// Step chains
	////////////////////////////////////////////////////////////

	assign phase_end = (phase == 2'(PHASES - 1));
	assign phase_d   = phase + 1'b1;

	// Shift one step per phase end, insert on start
	always_comb begin
		chain_d = chain;
		if (phase_end) begin
			for (int c = 0; c < NUM_CMDS; c++) begin
				chain_d[c][0] = start && (start_cmd == psram_cmd_t'(c));
				for (int s = 1; s < MAX_STEPS; s++) begin
					chain_d[c][s] = chain[c][s-1] && (s < step_count(psram_cmd_t'(c)));
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= '0;
			chain <= '0;
		end else begin
			phase <= phase_d;
			chain <= chain_d;
		end
	end

	// Incoming word is used directly on its first phase
	assign word_sel   = wready ? wdata : word_reg;
	assign addr_bytes = {{(32 - ADDR_W){1'b0}}, mem_addr};

	always_ff @(posedge clk) begin
		if (wready) begin
			word_reg <= wdata;
		end
	end

	// OR of all entries whose step is active next cycle
	always_comb begin
		next_entry = '0;
		for (int c = 0; c < NUM_CMDS; c++) begin
			for (int s = 0; s < MAX_STEPS; s++) begin
				if (chain_d[c][s]) begin
					next_entry = next_entry |
						step_entry(psram_cmd_t'(c), s, phase_d, addr_bytes, word_sel);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pads  <= '0;
			latch <= '0;
		end else begin
			pads  <= next_entry.pads;
			latch <= next_entry.latch;
		end
	end

	// Word request one step ahead of each data step
	assign wready = phase_end &&
		(|chain[cmd_write_mem][WRITE_MEM_STEPS-2:FIRST_DATA_STEP-1]);

	always_comb begin
		last_step = 1'b0;
		for (int c = 0; c < NUM_CMDS; c++) begin
			last_step = last_step ||
				(phase_end && chain[c][step_count(psram_cmd_t'(c)) - 1]);
		end
	end

endmodule

//--- psram_sequencer.sv
// PSRAM start-up and request sequencer

module psram_sequencer (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       awvalid,
	input  psram_host_pkg::host_addr_t awaddr,
	input  logic                       arvalid,
	input  psram_host_pkg::host_addr_t araddr,
	input  logic                       last_step,
	input  logic                       phase_end,
	input  logic                       expired,
	output logic                       awready,
	output logic                       arready,
	output logic                       bvalid,
	output logic                       psram_ready,
	output psram_spi_pkg::psram_cmd_t  start_cmd,
	output logic                       start,
	output logic                       timer_load,
	output logic                       timer_sel,
	output psram_host_pkg::host_addr_t mem_addr
);
	import psram_spi_pkg::*;
	import psram_host_pkg::*;

	typedef enum logic [3:0] {
		st_idle,
		st_startup,
		st_reset,
		st_reset_wait,
		st_settle,
		st_settle_wait,
		st_read_id,
		st_read_id_wait,
		st_write_cr0,
		st_write_cr0_wait,
		st_ready,
		st_read,
		st_read_wait,
		st_write,
		st_write_wait
	} seq_state_t;

	seq_state_t state;
	seq_state_t next_state;
	logic       issue;

	////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			st_idle:           next_state = st_startup;
			// Power-up wait
			st_startup:        if (expired) next_state = st_reset;
			// Reset enable, then soft reset
			st_reset:          if (phase_end) next_state = st_reset_wait;
			st_reset_wait:     if (last_step) next_state = st_settle;
			st_settle:         next_state = st_settle_wait;
			st_settle_wait:    if (expired) next_state = st_read_id;
			st_read_id:        if (phase_end) next_state = st_read_id_wait;
			st_read_id_wait:   if (last_step) next_state = st_write_cr0;
			st_write_cr0:      if (phase_end) next_state = st_write_cr0_wait;
			st_write_cr0_wait: if (last_step) next_state = st_ready;
			// Writes win over reads
			st_ready: begin
				if (awready) begin
					next_state = st_write;
				end else if (arready) begin
					next_state = st_read;
				end
			end
			st_read:           if (phase_end) next_state = st_read_wait;
			st_read_wait:      if (last_step) next_state = st_ready;
			st_write:          if (phase_end) next_state = st_write_wait;
			st_write_wait:     if (last_step) next_state = st_ready;
			default:           next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= st_idle;
			psram_ready <= 1'b0;
			bvalid      <= 1'b0;
		end else begin
			state       <= next_state;
			// Sticky once start-up is done
			psram_ready <= psram_ready || (state == st_ready);
			bvalid      <= (state == st_write_wait) && last_step;
		end
	end

	////////////////////////////////////////////////////////////
	// Command issue
	////////////////////////////////////////////////////////////

	assign issue = (state == st_reset) || (state == st_read_id) ||
		(state == st_write_cr0) || (state == st_read) || (state == st_write);

	// Only at a phase end, so step 0 starts on phase 0
	assign start = issue && phase_end;

	always_comb begin
		case (state)
			st_read_id:   start_cmd = cmd_read_id;
			st_write_cr0: start_cmd = cmd_write_cr0;
			st_read:      start_cmd = cmd_read_mem;
			st_write:     start_cmd = cmd_write_mem;
			default:      start_cmd = cmd_reset;
		endcase
	end

	// Timer reload for start-up and settle waits
	assign timer_load = (state == st_idle) || (state == st_settle);
	assign timer_sel  = (state == st_settle);

	// Host address handshake
	assign awready = (state == st_ready) && psram_ready && awvalid;
	assign arready = (state == st_ready) && psram_ready && !awvalid && arvalid;

	// Aligned burst address
	always_ff @(posedge clk) begin
		if (awready) begin
			mem_addr <= {awaddr[ADDR_W-1:WR_ALIGN_BITS], {WR_ALIGN_BITS{1'b0}}};
		end else if (arready) begin
			mem_addr <= {araddr[ADDR_W-1:RD_ALIGN_BITS], {RD_ALIGN_BITS{1'b0}}};
		end
	end

endmodule

//--- psram_delay_timer.sv
// Start-up and settle delay timer

module psram_delay_timer (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic sel,
	output logic expired
);
	import psram_spi_pkg::*;

	wait_cnt_t count;

	// Down-counter, parks at zero
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= STARTUP_CYCLES;
		end else if (load) begin
			// sel high picks the short settle wait
			count <= sel ? SETTLE_CYCLES : STARTUP_CYCLES;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign expired = (count == '0);

endmodule

//--- psram_host_pkg.sv
// Host port definitions

package psram_host_pkg;

	// Byte address into the 32 Mbyte array
	localparam int ADDR_W = 25;
	localparam int DATA_W = 16;

	// Burst alignment in address bits
	localparam int RD_ALIGN_BITS = 3;
	localparam int WR_ALIGN_BITS = 4;

	// Write response, always OKAY
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef logic [ADDR_W-1:0] host_addr_t;
	typedef logic [DATA_W-1:0] host_word_t;

	// Captured byte with its strobe
	typedef struct packed {
		logic       rwds;
		logic [7:0] data;
	} rd_byte_t;

	// Read word, first byte on top
	typedef struct packed {
		rd_byte_t first;
		rd_byte_t second;
	} read_word_t;

endpackage

//--- psram_spi_pkg.sv
// PSRAM SPI8 bus definitions

package psram_spi_pkg;

	// Bus commands, one step chain each
	typedef enum logic [2:0] {
		cmd_reset     = 3'd0,
		cmd_read_id   = 3'd1,
		cmd_write_cr0 = 3'd2,
		cmd_read_mem  = 3'd3,
		cmd_write_mem = 3'd4
	} psram_cmd_t;

	localparam int NUM_CMDS = 5;

	// Registered pad outputs, cs active high
	typedef struct packed {
		logic       sclk;
		logic       cs;
		logic [7:0] data_out;
		logic       data_oe;
		logic       rwds_out;
		logic       rwds_oe;
	} spi_pads_t;

	// Clock phases per step
	localparam int PHASES = 4;

	// Steps per command
	localparam int RESET_STEPS     = 3;
	localparam int READ_ID_STEPS   = 21;
	localparam int WRITE_CR0_STEPS = 8;
	localparam int READ_MEM_STEPS  = 15;
	localparam int WRITE_MEM_STEPS = 18;
	localparam int MAX_STEPS       = READ_ID_STEPS;

	// Command step plus two address steps
	localparam int CMD_HDR_STEPS   = 3;
	// First read latch or write data step
	localparam int FIRST_DATA_STEP = 10;

	localparam logic [7:0] RESET_ENABLE_BYTE = 8'h66;
	localparam logic [7:0] RESET_BYTE        = 8'h99;
	localparam logic [7:0] READ_ID_BYTE      = 8'h9F;
	localparam logic [7:0] WRITE_ENABLE_BYTE = 8'h06;
	localparam logic [7:0] WRITE_REG_BYTE    = 8'h71;
	localparam logic [7:0] READ_MEM_BYTE     = 8'hEE;
	localparam logic [7:0] WRITE_MEM_BYTE    = 8'hDE;

	// CR0 sets read latency 3
	localparam logic [31:0] CR0_ADDR  = 32'h0000_0004;
	localparam logic [15:0] CR0_VALUE = 16'h8FEF;

	// Wait lengths in clk cycles
	typedef logic [12:0] wait_cnt_t;
	localparam wait_cnt_t STARTUP_CYCLES = 13'd7200;
	localparam wait_cnt_t SETTLE_CYCLES  = 13'd20;

endpackage
